// File: bypass_if.sv
`default_nettype none

// Late-stage results fed back to execute and the register file
interface bypass_if;
    import core_pkg::*;

    reg_addr_t mem_rd;
    logic      mem_reg_write;
    word_t     mem_result;    // Address or ALU result from EX/MEM

    reg_addr_t wb_rd;
    logic      wb_reg_write;
    word_t     wb_data;       // Final writeback value

    modport driver (
        output mem_rd, mem_reg_write, mem_result,
        output wb_rd, wb_reg_write, wb_data
    );

    modport sink (
        input mem_rd, mem_reg_write, mem_result,
        input wb_rd, wb_reg_write, wb_data
    );

endinterface

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

    // ==================================================
    // Widths and base types
    // ==================================================
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // RV32I major opcodes in use
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // Branch conditions by funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add,  // Also address and link arithmetic
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // ==================================================
    // Stage payloads
    // ==================================================
    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic [2:0] funct3;
        alu_op_t   alu_op;
        logic      use_imm;   // Operand B from immediate
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      jump;
        logic      is_jalr;
    } id_ex_t;

    typedef struct packed {
        word_t     result;      // ALU result, address or link
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: core_top.sv
`default_nettype none

module core_top #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  core_pkg::word_t instr,
    output core_pkg::word_t pc_addr,
    output core_pkg::word_t dmem_addr,
    output core_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    output logic            dmem_re,
    input  core_pkg::word_t dmem_rdata
);
    import core_pkg::*;

    // ==================================================
    // Inter-stage wiring
    // ==================================================
    word_t     if_pc;
    word_t     if_instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      stall;
    logic      redirect;
    word_t     redirect_target;
    reg_addr_t ex_rd;
    logic      ex_mem_read;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;

    bypass_if byp ();  // MEM and WB results

    fetch_stage #(
        .reset_pc (reset_pc)
    ) fetch_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr           (instr),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc_addr         (pc_addr),
        .if_pc           (if_pc),
        .if_instr        (if_instr)
    );

    decode_stage decode_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .if_pc       (if_pc),
        .if_instr    (if_instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .redirect    (redirect),
        .ex_rd       (ex_rd),
        .ex_mem_read (ex_mem_read),
        .stall       (stall),
        .id_ex       (id_ex)
    );

    regfile regfile_i (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (byp.sink)
    );

    execute_stage execute_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_ex           (id_ex),
        .byp             (byp.sink),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .ex_rd           (ex_rd),
        .ex_mem_read     (ex_mem_read),
        .ex_mem          (ex_mem)
    );

    memory_stage memory_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .byp        (byp.driver)
    );

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::word_t     if_pc,
    input  core_pkg::word_t     if_instr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  logic                redirect,
    input  core_pkg::reg_addr_t ex_rd,
    input  logic                ex_mem_read,
    output logic                stall,
    output core_pkg::id_ex_t    id_ex
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_bit;    // Bit 30 picks SUB and SRA
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;

    alu_op_t alu_sel;
    logic    uses_rs1;
    logic    uses_rs2;
    id_ex_t  dec;

    // ==================================================
    // Fields and immediates
    // ==================================================
    assign opcode  = if_instr[6:0];
    assign rd      = if_instr[11:7];
    assign funct3  = if_instr[14:12];
    assign rs1     = if_instr[19:15];
    assign rs2     = if_instr[24:20];
    assign alt_bit = if_instr[30];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                    if_instr[20], if_instr[30:21], 1'b0};

    assign rs1_addr = rs1;
    assign rs2_addr = rs2;

    // ALU operation for register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (opcode == op_reg && alt_bit) ? alu_sub : alu_add;
            3'b001:  alu_sel = alu_sll;
            3'b010:  alu_sel = alu_slt;
            3'b011:  alu_sel = alu_sltu;
            3'b100:  alu_sel = alu_xor;
            3'b101:  alu_sel = alt_bit ? alu_sra : alu_srl;
            3'b110:  alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
    end

    // ==================================================
    // Control decode
    // ==================================================
    always_comb begin
        dec          = '0;
        dec.pc       = if_pc;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rd       = rd;
        dec.funct3   = funct3;
        dec.imm      = imm_i;
        dec.alu_op   = alu_add;
        case (opcode)
            op_reg: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_sel;
            end
            op_imm: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.alu_op    = alu_sel;
            end
            op_load: begin
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
                dec.use_imm   = 1'b1;
            end
            op_store: begin
                dec.mem_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = imm_s;
            end
            op_branch: begin
                dec.branch = 1'b1;
                dec.imm    = imm_b;
            end
            op_jal: begin
                dec.jump      = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = imm_j;
            end
            op_jalr: begin
                dec.jump      = 1'b1;
                dec.is_jalr   = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: ;  // Anything else runs as a bubble
        endcase
    end

    // Load-use hazard against the instruction now in execute
    assign uses_rs1 = (opcode != op_jal);
    assign uses_rs2 = (opcode == op_reg) || (opcode == op_store) || (opcode == op_branch);

    assign stall = ex_mem_read && (ex_rd != '0) &&
                   ((uses_rs1 && (ex_rd == rs1)) || (uses_rs2 && (ex_rd == rs2)));

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (stall || redirect) begin
            id_ex <= '0;    // Bubble
        end else begin
            id_ex <= dec;
        end
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::id_ex_t    id_ex,
    bypass_if.sink              byp,
    output logic                redirect,
    output core_pkg::word_t     redirect_target,
    output core_pkg::reg_addr_t ex_rd,
    output logic                ex_mem_read,
    output core_pkg::ex_mem_t   ex_mem
);
    import core_pkg::*;

    word_t  opnd_a;
    word_t  fwd_b;
    word_t  opnd_b;
    word_t  alu_out;
    word_t  jalr_sum;
    logic   branch_cond;
    ex_mem_t ex_next;

    // Memory stage first, then writeback, then the register file value
    function automatic word_t forward(input reg_addr_t rs, input word_t rf_val);
        if (rs == '0) begin
            return rf_val;
        end
        if (byp.mem_reg_write && (byp.mem_rd == rs)) begin
            return byp.mem_result;
        end
        if (byp.wb_reg_write && (byp.wb_rd == rs)) begin
            return byp.wb_data;
        end
        return rf_val;
    endfunction

    assign opnd_a = forward(id_ex.rs1, id_ex.rs1_data);
    assign fwd_b  = forward(id_ex.rs2, id_ex.rs2_data);
    assign opnd_b = id_ex.use_imm ? id_ex.imm : fwd_b;

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        case (id_ex.alu_op)
            alu_sub:  alu_out = opnd_a - opnd_b;
            alu_and:  alu_out = opnd_a & opnd_b;
            alu_or:   alu_out = opnd_a | opnd_b;
            alu_xor:  alu_out = opnd_a ^ opnd_b;
            alu_slt:  alu_out = {31'b0, $signed(opnd_a) < $signed(opnd_b)};
            alu_sltu: alu_out = {31'b0, opnd_a < opnd_b};
            alu_sll:  alu_out = opnd_a << opnd_b[4:0];
            alu_srl:  alu_out = opnd_a >> opnd_b[4:0];
            alu_sra:  alu_out = word_t'($signed(opnd_a) >>> opnd_b[4:0]);
            default:  alu_out = opnd_a + opnd_b;
        endcase
    end

    // Branch compare uses both forwarded registers
    always_comb begin
        case (id_ex.funct3)
            f3_beq:  branch_cond = (opnd_a == fwd_b);
            f3_bne:  branch_cond = (opnd_a != fwd_b);
            f3_blt:  branch_cond = ($signed(opnd_a) < $signed(fwd_b));
            f3_bge:  branch_cond = ($signed(opnd_a) >= $signed(fwd_b));
            f3_bltu: branch_cond = (opnd_a < fwd_b);
            f3_bgeu: branch_cond = (opnd_a >= fwd_b);
            default: branch_cond = 1'b0;
        endcase
    end

    // ==================================================
    // Control transfer
    // ==================================================
    assign jalr_sum = opnd_a + id_ex.imm;

    assign redirect        = (id_ex.branch && branch_cond) || id_ex.jump;
    assign redirect_target = id_ex.is_jalr ? {jalr_sum[xlen-1:1], 1'b0}
                                           : id_ex.pc + id_ex.imm;

    // For the load-use check in decode
    assign ex_rd       = id_ex.rd;
    assign ex_mem_read = id_ex.mem_read;

    always_comb begin
        ex_next.result     = id_ex.jump ? id_ex.pc + 32'd4 : alu_out;  // Link value
        ex_next.store_data = fwd_b;
        ex_next.rd         = id_ex.rd;
        ex_next.reg_write  = id_ex.reg_write;
        ex_next.mem_read   = id_ex.mem_read;
        ex_next.mem_write  = id_ex.mem_write;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_next;
        end
    end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`default_nettype none

module fetch_stage #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  core_pkg::word_t instr,
    input  logic            stall,
    input  logic            redirect,
    input  core_pkg::word_t redirect_target,
    output core_pkg::word_t pc_addr,
    output core_pkg::word_t if_pc,
    output core_pkg::word_t if_instr
);
    import core_pkg::*;

    // ADDI x0, x0, 0
    localparam word_t nop_instr = {25'b0, op_imm};

    word_t pc;
    word_t pc_next;

    // Redirect beats stall
    assign pc_next = redirect ? redirect_target :
                     stall    ? pc :
                                pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_addr = pc;

    // ==================================================
    // IF/ID register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_pc    <= '0;
            if_instr <= nop_instr;
        end else if (redirect) begin
            if_pc    <= '0;
            if_instr <= nop_instr;  // Squash wrong-path fetch
        end else if (!stall) begin
            if_pc    <= pc;
            if_instr <= instr;
        end
    end

endmodule

`default_nettype wire

// File: memory_stage.sv
`default_nettype none

module memory_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::ex_mem_t ex_mem,
    output core_pkg::word_t   dmem_addr,
    output core_pkg::word_t   dmem_wdata,
    output logic              dmem_we,
    output logic              dmem_re,
    input  core_pkg::word_t   dmem_rdata,
    bypass_if.driver          byp
);
    import core_pkg::*;

    reg_addr_t wb_rd_q;
    logic      wb_reg_write_q;
    word_t     wb_data_q;

    // Word-wide data bus straight from EX/MEM
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_write;
    assign dmem_re    = ex_mem.mem_read;

    // ==================================================
    // MEM/WB register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rd_q        <= '0;
            wb_reg_write_q <= 1'b0;
        end else begin
            wb_rd_q        <= ex_mem.rd;
            wb_reg_write_q <= ex_mem.reg_write;
        end
    end

    // Load data or ALU result
    always_ff @(posedge clk) begin
        wb_data_q <= ex_mem.mem_read ? dmem_rdata : ex_mem.result;
    end

    assign byp.mem_rd        = ex_mem.rd;
    assign byp.mem_reg_write = ex_mem.reg_write;
    assign byp.mem_result    = ex_mem.result;

    assign byp.wb_rd        = wb_rd_q;
    assign byp.wb_reg_write = wb_reg_write_q;
    assign byp.wb_data      = wb_data_q;

endmodule

`default_nettype wire

// File: project.f
core_pkg.sv
bypass_if.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core_top.sv
tb_core.sv

// File: regfile.sv
`default_nettype none

module regfile (
    input  logic                clk,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    bypass_if.sink              wb
);
    import core_pkg::*;

    word_t regs [0:31];

    logic wr_en;

    assign wr_en = wb.wb_reg_write && (wb.wb_rd != '0);

    // Same-cycle write shows up on the read port
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;  // x0 is hardwired
        end
        if (wr_en && (wb.wb_rd == addr)) begin
            return wb.wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.wb_rd] <= wb.wb_data;
        end
    end

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

endmodule

`default_nettype wire

// File: tb_core.sv
`default_nettype none

module tb_core;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int          reset_cycles   = 16;
    localparam int          timeout_cycles = 600;
    localparam int          imem_depth     = 256;
    localparam int          dmem_depth     = 256;
    localparam logic [31:0] seed           = 32'h21fa_8ed9;
    localparam word_t       start_pc       = '0;
    localparam logic [11:0] poison_off     = 12'h3fc;
    localparam word_t       nop_word       = 32'h0000_0013;  // ADDI x0, x0, 0

    // ALU op codes as {alt, funct3}
    localparam logic [3:0] r_ops [0:9] = '{4'h0, 4'h8, 4'h7, 4'h6, 4'h4,
                                           4'h2, 4'h3, 4'h1, 4'h5, 4'hd};
    localparam logic [3:0] i_ops [0:9] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6,
                                           4'h7, 4'h1, 4'h5, 4'hd, 4'h0};
    localparam logic [2:0] branch_f3s [0:5] = '{f3_beq, f3_bne, f3_blt,
                                                f3_bge, f3_bltu, f3_bgeu};

    logic  clk   = 1'b0;
    logic  rst_n = 1'b0;
    word_t instr;
    word_t pc_addr;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    logic  dmem_re;
    word_t dmem_rdata;

    word_t imem [0:imem_depth-1];
    word_t dmem [0:dmem_depth-1];

    // Assembler state and reference model
    int unsigned asm_idx = 0;
    int unsigned slot    = 0;
    word_t       regs_model [0:31];
    word_t       mem_model [word_t];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    string       exp_name [$];
    word_t       lu_pc;
    word_t       lu_addr;
    word_t       jalr_pc;
    word_t       jalr_target;

    int    cycles        = 0;
    int    stall_repeats = 0;
    int    load_reads    = 0;
    word_t last_pc       = '0;
    logic  last_jump     = 1'b0;
    logic  last_rst      = 1'b0;
    word_t seq_pc;

    always #20 clk = ~clk;

    core_top core_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .pc_addr    (pc_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    assign instr      = imem[pc_addr[9:2]];  // Combinational fetch
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // ==================================================
    // Failure reporting
    // ==================================================
    task automatic report_mismatch(input string test, input word_t expected, input word_t actual);
        $display("FAIL %s: expected %08h, actual %08h", test, expected, actual);
        $display("TB FAILED");
        $fatal(1, "Check failed in %s", test);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    // ==================================================
    // Reference model and assembler
    // ==================================================
    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            f3_beq:  return a == b;
            f3_bne:  return a != b;
            f3_blt:  return $signed(a) < $signed(b);
            f3_bge:  return $signed(a) >= $signed(b);
            f3_bltu: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [11:0] slot_off();
        return 12'h100 + 12'(slot * 4);
    endfunction

    task automatic put_word(input word_t w);
        imem[asm_idx] = w;
        asm_idx++;
    endtask

    task automatic set_reg(input reg_addr_t rd, input word_t v);
        if (rd != '0) begin
            regs_model[rd] = v;
        end
    endtask

    task automatic r_type(input logic [2:0] f3, input logic alt,
                          input reg_addr_t rd, rs1, rs2);
        put_word({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, op_reg});
        set_reg(rd, ref_alu(f3, alt, regs_model[rs1], regs_model[rs2]));
    endtask

    task automatic i_type(input logic [2:0] f3, input logic alt,
                          input reg_addr_t rd, rs1, input logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        if (f3 == 3'b001 || f3 == 3'b101) begin
            field = {1'b0, alt, 5'b0, imm[4:0]};  // Shift amount only
        end
        put_word({field, rs1, f3, rd, op_imm});
        set_reg(rd, ref_alu(f3, alt && (f3 == 3'b101), regs_model[rs1], sext12(field)));
    endtask

    task automatic sw(input reg_addr_t rs2, input string name);
        logic [11:0] off;
        off = slot_off();
        put_word({off[11:5], rs2, 5'd0, 3'b010, off[4:0], op_store});
        mem_model[word_t'(off)] = regs_model[rs2];
        exp_addr.push_back(word_t'(off));
        exp_data.push_back(regs_model[rs2]);
        exp_name.push_back(name);
        slot++;
    endtask

    task automatic poison_store();
        put_word({poison_off[11:5], 5'd1, 5'd0, 3'b010, poison_off[4:0], op_store});
    endtask

    task automatic lw(input reg_addr_t rd, input logic [11:0] off);
        put_word({off, 5'd0, 3'b010, rd, op_load});
        set_reg(rd, mem_model[word_t'(off)]);
    endtask

    task automatic branch(input logic [2:0] f3, input reg_addr_t rs1, rs2,
                          input logic [12:0] off);
        put_word({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch});
    endtask

    task automatic jal(input reg_addr_t rd, input logic [20:0] off);
        word_t here;
        here = word_t'(asm_idx * 4);
        put_word({off[20], off[10:1], off[11], off[19:12], rd, op_jal});
        set_reg(rd, here + 32'd4);
    endtask

    task automatic jalr(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        word_t here;
        here = word_t'(asm_idx * 4);
        put_word({imm, rs1, 3'b000, rd, op_jalr});
        set_reg(rd, here + 32'd4);
    endtask

    // Dependent chain with distance-one and distance-two operands
    task automatic alu_chain(input int k);
        logic [3:0] ra;
        logic [3:0] rb;
        logic [3:0] ia;
        logic [3:0] ib;
        ra = r_ops[2*k];
        rb = r_ops[2*k+1];
        ia = i_ops[2*k];
        ib = i_ops[2*k+1];
        i_type(3'b000, 1'b0, 5'd1, 5'd0, 12'($urandom));
        i_type(ia[2:0], ia[3], 5'd2, 5'd1, 12'($urandom));
        r_type(ra[2:0], ra[3], 5'd3, 5'd2, 5'd1);
        r_type(rb[2:0], rb[3], 5'd4, 5'd3, 5'd2);
        i_type(ib[2:0], ib[3], 5'd5, 5'd4, 12'($urandom));
        sw(5'd4, $sformatf("alu_chain_%0d_r", k));
        sw(5'd5, $sformatf("alu_chain_%0d_i", k));
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic want);
        logic [11:0] ia;
        logic [11:0] ib;
        logic [11:0] tmp;
        ia = 12'($urandom);
        do begin
            ib = 12'($urandom);
        end while (ib == ia);
        if ((f3 == f3_beq && want) || (f3 == f3_bne && !want)) begin
            ib = ia;
        end else if (branch_taken(f3, sext12(ia), sext12(ib)) != want) begin
            tmp = ia;
            ia  = ib;
            ib  = tmp;
        end
        i_type(3'b000, 1'b0, 5'd5, 5'd0, ia);
        i_type(3'b000, 1'b0, 5'd6, 5'd0, ib);
        branch(f3, 5'd5, 5'd6, 13'd12);  // Target skips two words
        if (want) begin
            poison_store();
            poison_store();
        end else begin
            sw(5'd5, $sformatf("branch_%0d_fall_a", f3));
            sw(5'd6, $sformatf("branch_%0d_fall_b", f3));
        end
    endtask

    task automatic build_program();
        logic [11:0] lu_off;
        for (int k = 0; k < 5; k++) begin
            alu_chain(k);
        end
        i_type(3'b000, 1'b0, 5'd7, 5'd0, 12'($urandom));
        i_type(3'b000, 1'b0, 5'd8, 5'd0, 12'($urandom));
        lu_off  = slot_off();
        lu_addr = word_t'(lu_off);
        sw(5'd7, "load_use_store");
        lu_pc = word_t'(asm_idx * 4);
        lw(5'd9, lu_off);
        r_type(3'b000, 1'b0, 5'd10, 5'd9, 5'd8);  // Needs the load result at once
        sw(5'd10, "load_use_sum");
        for (int c = 0; c < 6; c++) begin
            branch_case(branch_f3s[c], 1'b1);
            branch_case(branch_f3s[c], 1'b0);
        end
        jal(5'd11, 21'd12);
        poison_store();
        poison_store();
        sw(5'd11, "jal_link");
        jalr_pc     = word_t'((asm_idx + 1) * 4);
        jalr_target = jalr_pc + 32'd16;
        i_type(3'b000, 1'b0, 5'd12, 5'd0, jalr_target[11:0]);
        jalr(5'd13, 5'd12, 12'd1);  // Odd sum so bit 0 must drop
        poison_store();
        poison_store();
        poison_store();
        sw(5'd13, "jalr_link");
        jal(5'd0, 21'd0);  // Park here
    endtask

    // ==================================================
    // Checks
    // ==================================================
    always @(posedge clk) begin
        last_pc   <= pc_addr;
        last_jump <= core_top_i.redirect;
        last_rst  <= rst_n;
        if (rst_n && last_rst && pc_addr == last_pc) begin
            stall_repeats <= stall_repeats + 1;
        end
        if (rst_n && dmem_re) begin
            load_reads <= load_reads + 1;
        end
    end

    // A held PC is legal only at the load-use point
    assign seq_pc = last_pc + 32'd4;

    reset_pc_check: assert property (@(posedge clk)
        ((cycles > 0 && !rst_n) || $rose(rst_n)) |-> pc_addr == start_pc)
        else report_mismatch("reset_pc", start_pc, $sampled(pc_addr));

    reset_bus_check: assert property (@(posedge clk)
        ((cycles > 0 && !rst_n) || $rose(rst_n)) |-> !dmem_we && !dmem_re)
        else report_failure("Data bus strobe active during or right after reset");

    pc_seq_check: assert property (@(posedge clk)
        (rst_n && last_rst && !last_jump) |-> (pc_addr == seq_pc || pc_addr == last_pc))
        else report_mismatch("pc_sequence", $sampled(seq_pc), $sampled(pc_addr));

    stall_pc_check: assert property (@(posedge clk)
        (rst_n && last_rst && pc_addr == last_pc) |-> pc_addr == lu_pc + 32'd8)
        else report_mismatch("load_use_stall_pc", lu_pc + 32'd8, $sampled(pc_addr));

    jalr_target_check: assert property (@(posedge clk)
        (rst_n && last_rst && last_pc == jalr_pc + 32'd8) |-> pc_addr == jalr_target)
        else report_mismatch("jalr_target", jalr_target, $sampled(pc_addr));

    load_addr_check: assert property (@(posedge clk)
        (rst_n && dmem_re) |-> dmem_addr == lu_addr)
        else report_mismatch("load_address", lu_addr, $sampled(dmem_addr));

    poison_check: assert property (@(posedge clk)
        (rst_n && dmem_we) |-> dmem_addr != word_t'(poison_off))
        else report_failure("A flushed store reached the data bus");

    // Stores leave in program order
    always @(posedge clk) begin
        if (rst_n && dmem_we) begin
            if (exp_addr.size() == 0) begin
                report_failure("A store appeared after the last expected store");
            end else begin
                store_addr_ok: assert (dmem_addr == exp_addr[0])
                    else report_mismatch({exp_name[0], " address"}, exp_addr[0], dmem_addr);
                store_data_ok: assert (dmem_wdata == exp_data[0])
                    else report_mismatch({exp_name[0], " data"}, exp_data[0], dmem_wdata);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            if (exp_addr.size() != 0) begin
                report_failure($sformatf("Timeout, the store for %s never appeared",
                                         exp_name[0]));
            end else begin
                report_failure("Timeout before the program finished");
            end
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(seed));
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = nop_word;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            dmem[i] = (word_t'(i) * 32'h0001_0003) ^ 32'h5a5a_a5a5;
        end
        for (int r = 0; r < 32; r++) begin
            regs_model[r] = '0;
        end
        build_program();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        while (exp_addr.size() != 0) begin
            @(negedge clk);
        end
        if (stall_repeats != 1) begin
            report_mismatch("load_use_stall_count", 32'd1, word_t'(stall_repeats));
        end else if (load_reads != 1) begin
            report_mismatch("load_read_count", 32'd1, word_t'(load_reads));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
